/* list.f */
rtl/arb_pkg.sv
rtl/rr_select.sv
rtl/slot_pool.sv
rtl/arb_mul.sv
rtl/arb_apb_regs.sv
rtl/arb_top.sv
bench/tb_arb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_arb_top -o tb_arb_top &&
./obj_dir/tb_arb_top | tee /dev/stderr | grep "Simulation passed" > /dev/null &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/tb_arb_top.sv */
`timescale 1ns/1ns

module tb_arb_top import arb_pkg::*; ();

    localparam int n_cycles = 3000;
    localparam int period   = 40;

    logic                      clk;
    logic                      rst;
    logic [ports_n-1:0]        req;
    logic [ports_n-1:0]        gnt;
    logic [ports_n*gnts_w-1:0] gnt_id;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_aw-1:0]         paddr;
    logic [apb_dw-1:0]         pwdata;
    logic [apb_dw-1:0]         prdata;
    logic                      pready;
    logic                      pslverr;

    // reference model state
    logic [ports_n-1:0] m_gnt;
    logic [gnts_w-1:0]  m_id [ports_n];
    logic [gnts_n-1:0]  m_free;
    logic [ports_n-1:0] m_mask;
    int                 m_ptr;
    int                 m_cnt;

    int          errors;
    int          timer [ports_n];

    arb_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .gnt     (gnt),
        .gnt_id  (gnt_id),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;

    function automatic bit is_mapped(input logic [apb_aw-1:0] addr);
        return addr inside {addr_mask, addr_gnt, addr_free, addr_cnt};
    endfunction

    // register contents as the model sees them
    function automatic logic [apb_dw-1:0] expected_read(input logic [apb_aw-1:0] addr);
        case (addr)
            addr_mask: return apb_dw'(m_mask);
            addr_gnt:  return apb_dw'(m_gnt);
            addr_free: return apb_dw'($countones(m_free));
            addr_cnt:  return apb_dw'(m_cnt);
            default:   return '0;
        endcase
    endfunction

    // one clock of setup and one clock of access
    task automatic apb_transfer(input bit wr, input logic [apb_aw-1:0] addr,
                                input logic [apb_dw-1:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [apb_dw-1:0] data);
        apb_transfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [apb_aw-1:0] addr);
        apb_transfer(1'b0, addr, '0);
    endtask

    // compare against the model and then step it by one clock
    always @(posedge clk) begin
        int pick;
        int idx;
        int low;
        bit grant;
        logic [gnts_n-1:0] rel;
        logic [gnts_n-1:0] seen;
        if (rst) begin
            m_gnt  = '0;
            m_free = '1;
            m_mask = '1;
            m_ptr  = 0;
            m_cnt  = 0;
        end else begin
            assert (gnt == m_gnt) else begin
                errors++;
                $display("MISMATCH at %0t: gnt %h, expected %h", $time, gnt, m_gnt);
            end
            seen = '0;
            for (int i = 0; i < ports_n; i++) begin
                if (m_gnt[i]) begin
                    assert (gnt_id[i*gnts_w +: gnts_w] == m_id[i]) else begin
                        errors++;
                        $display("MISMATCH at %0t: port %0d id %0d, expected %0d",
                                 $time, i, gnt_id[i*gnts_w +: gnts_w], m_id[i]);
                    end
                end
                if (gnt[i]) begin
                    assert (!seen[gnt_id[i*gnts_w +: gnts_w]]) else begin
                        errors++;
                        $display("two granted ports share slot %0d at %0t",
                                 gnt_id[i*gnts_w +: gnts_w], $time);
                    end
                    seen[gnt_id[i*gnts_w +: gnts_w]] = 1'b1;
                end
            end
            assert ($countones(gnt) <= gnts_n) else begin
                errors++;
                $display("more grants than slots at %0t", $time);
            end
            assert (pready) else begin
                errors++;
                $display("pready went low at %0t", $time);
            end
            assert (pslverr == (psel && penable && !is_mapped(paddr))) else begin
                errors++;
                $display("MISMATCH at %0t: pslverr %b at address %h", $time, pslverr, paddr);
            end
            if (psel && penable && !pwrite) begin
                assert (prdata == expected_read(paddr)) else begin
                    errors++;
                    $display("MISMATCH at %0t: read %h gave %h, expected %h",
                             $time, paddr, prdata, expected_read(paddr));
                end
            end

            // slots of dropped requests go back to the pool
            rel = '0;
            for (int i = 0; i < ports_n; i++) begin
                if (m_gnt[i] && !req[i]) begin
                    rel[m_id[i]] = 1'b1;
                end
            end
            pick = -1;
            for (int k = 0; k < ports_n; k++) begin
                idx = (m_ptr + k) % ports_n;
                if (pick < 0 && req[idx] && m_mask[idx] && !m_gnt[idx]) begin
                    pick = idx;
                end
            end
            low = -1;
            for (int s = 0; s < gnts_n; s++) begin
                if (low < 0 && m_free[s]) begin
                    low = s;
                end
            end
            grant  = (pick >= 0) && (low >= 0);
            m_gnt  = m_gnt & req;
            m_free = m_free | rel;
            if (grant) begin
                m_gnt[pick]  = 1'b1;
                m_id[pick]   = low[gnts_w-1:0];
                m_free[low]  = 1'b0;
                m_ptr        = (pick + 1) % ports_n;
            end
            // clear beats a grant in the same cycle
            if (psel && penable && pwrite && paddr == addr_cnt) begin
                m_cnt = 0;
            end else if (grant && m_cnt < (2 ** cnt_w) - 1) begin
                m_cnt++;
            end
            if (psel && penable && pwrite && paddr == addr_mask) begin
                m_mask = pwdata[ports_n-1:0];
            end
        end
    end

    // software traffic runs until the main process ends the test
    initial begin
        int op;
        repeat (4) @(negedge clk);
        forever begin
            repeat ($urandom_range(2, 12)) @(negedge clk);
            op = $urandom_range(0, 9);
            case (op)
                0: apb_write(addr_mask, $urandom & 32'h3ff);
                1: apb_write(addr_mask, 32'h3ff);
                2: apb_write(addr_cnt, $urandom);
                3: apb_read(addr_mask);
                4: apb_read(addr_free);
                5: apb_read(addr_gnt);
                6: apb_read(addr_cnt);
                7: apb_read(addr_free);
                // nonzero low address bits are never in the map
                8: apb_read({2'($urandom_range(0, 3)), 2'($urandom_range(1, 3))});
                default: apb_write({2'($urandom_range(0, 3)), 2'($urandom_range(1, 3))}, $urandom);
            endcase
        end
    end

    initial begin
        #((n_cycles + 200) * period);
        $display("timeout: the test did not finish within its cycle budget");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        bit heavy;
        void'($urandom(32'h144b_9d01));
        errors   = 0;
        clk      = 1'b0;
        rst      = 1'b1;
        req      = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        for (int i = 0; i < ports_n; i++) begin
            timer[i] = $urandom_range(0, 5);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // each port alternates idle and hold phases of random length
        for (int cyc = 0; cyc < n_cycles; cyc++) begin
            @(negedge clk);
            heavy = (cyc >= 1200) && (cyc < 1700);
            for (int i = 0; i < ports_n; i++) begin
                if (timer[i] > 0) begin
                    timer[i]--;
                end else if (req[i]) begin
                    req[i]   = 1'b0;
                    timer[i] = heavy ? 0 : $urandom_range(0, 6);
                end else begin
                    req[i]   = 1'b1;
                    timer[i] = heavy ? $urandom_range(10, 30) : $urandom_range(2, 16);
                end
            end
        end
        repeat (2) @(negedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rtl/arb_top.sv */
`timescale 1ns/1ns

module arb_top import arb_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ports_n-1:0]        req,
    output logic [ports_n-1:0]        gnt,
    output logic [ports_n*gnts_w-1:0] gnt_id,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_aw-1:0]         paddr,
    input  logic [apb_dw-1:0]         pwdata,
    output logic [apb_dw-1:0]         prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic [ports_n-1:0] en_mask;
    logic [free_w-1:0]  free_cnt;
    logic               new_gnt;

    arb_apb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .gnt      (gnt),
        .free_cnt (free_cnt),
        .new_gnt  (new_gnt),
        .en_mask  (en_mask)
    );

    arb_mul u_arb (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .en_mask  (en_mask),
        .gnt      (gnt),
        .gnt_id   (gnt_id),
        .free_cnt (free_cnt),
        .new_gnt  (new_gnt)
    );

endmodule

/* rtl/arb_apb_regs.sv */
`timescale 1ns/1ns

module arb_apb_regs import arb_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [apb_aw-1:0]  paddr,
    input  logic [apb_dw-1:0]  pwdata,
    output logic [apb_dw-1:0]  prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic [ports_n-1:0] gnt,
    input  logic [free_w-1:0]  free_cnt,
    input  logic               new_gnt,
    output logic [ports_n-1:0] en_mask
);

    logic             access;
    logic             wr;
    logic             mapped;
    logic             cnt_clr;
    logic [cnt_w-1:0] gnt_cnt;

    // zero wait states
    assign pready = 1'b1;

    assign access = psel & penable;
    assign wr     = access & pwrite;

    always_comb begin
        case (paddr)
            addr_mask, addr_gnt, addr_free, addr_cnt: mapped = 1'b1;
            default:                                  mapped = 1'b0;
        endcase
    end

    assign pslverr = access & ~mapped;
    assign cnt_clr = wr && (paddr == addr_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            en_mask <= '1;
        end else if (wr && (paddr == addr_mask)) begin
            en_mask <= pwdata[ports_n-1:0];
        end
    end

    // saturating grant counter
    // a clear in the same cycle as a grant wins
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_cnt <= '0;
        end else if (cnt_clr) begin
            gnt_cnt <= '0;
        end else if (new_gnt && (gnt_cnt != '1)) begin
            gnt_cnt <= gnt_cnt + 1'b1;
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        case (paddr)
            addr_mask: prdata = apb_dw'(en_mask);
            addr_gnt:  prdata = apb_dw'(gnt);
            addr_free: prdata = apb_dw'(free_cnt);
            addr_cnt:  prdata = apb_dw'(gnt_cnt);
            default:   prdata = '0;
        endcase
    end

    // access phase only ever follows a selected setup
    assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

/* rtl/arb_mul.sv */
`timescale 1ns/1ns

module arb_mul import arb_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ports_n-1:0]        req,
    input  logic [ports_n-1:0]        en_mask,
    output logic [ports_n-1:0]        gnt,
    output logic [ports_n*gnts_w-1:0] gnt_id,
    output logic [free_w-1:0]         free_cnt,
    output logic                      new_gnt
);

    logic [gnts_w-1:0]  id_r [ports_n];
    logic [ports_n-1:0] eligible;
    logic [ports_n-1:0] pick;
    logic               pick_valid;
    logic [ports_n-1:0] drop;
    logic [gnts_n-1:0]  release_mask;
    logic [gnts_w-1:0]  alloc_id;
    logic               has_free;
    logic               alloc;
    logic               id_clash;

    // waiting, enabled, not yet holding a slot
    assign eligible = req & en_mask & ~gnt;

    // granted ports whose request went away
    assign drop = gnt & ~req;

    assign alloc   = pick_valid & has_free;
    assign new_gnt = alloc;

    always_comb begin
        release_mask = '0;
        for (int i = 0; i < ports_n; i++) begin
            if (drop[i]) begin
                release_mask[id_r[i]] = 1'b1;
            end
        end
    end

    rr_select u_rr (
        .clk        (clk),
        .rst        (rst),
        .eligible   (eligible),
        .advance    (alloc),
        .pick       (pick),
        .pick_valid (pick_valid)
    );

    slot_pool u_pool (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_id     (alloc_id),
        .has_free     (has_free),
        .release_mask (release_mask),
        .free_cnt     (free_cnt)
    );

    // grant flags; the slot id is only meaningful while gnt is set
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt <= '0;
        end else begin
            gnt <= (gnt & ~drop) | (alloc ? pick : '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ports_n; i++) begin
            if (alloc && pick[i]) begin
                id_r[i] <= alloc_id;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ports_n; i++) begin
            gnt_id[i*gnts_w +: gnts_w] = id_r[i];
        end
    end

    // pairwise compare of held ids
    always_comb begin
        id_clash = 1'b0;
        for (int i = 0; i < ports_n - 1; i++) begin
            for (int j = i + 1; j < ports_n; j++) begin
                if (gnt[i] && gnt[j] && (id_r[i] == id_r[j])) begin
                    id_clash = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !id_clash);

    assert property (@(posedge clk) disable iff (rst) $countones(gnt) <= gnts_n);

endmodule

/* rtl/slot_pool.sv */
`timescale 1ns/1ns

module slot_pool import arb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    output logic [gnts_w-1:0] alloc_id,
    output logic              has_free,
    input  logic [gnts_n-1:0] release_mask,
    output logic [free_w-1:0] free_cnt
);

    // one bit per slot, set while the slot is free
    logic [gnts_n-1:0] free_map;
    logic [gnts_n-1:0] alloc_bit;

    assign has_free = |free_map;

    // lowest free id wins, scan from the top down
    always_comb begin
        alloc_id = '0;
        for (int i = gnts_n - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_id = gnts_w'(i);
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < gnts_n; i++) begin
            free_cnt = free_cnt + free_w'(free_map[i]);
        end
    end

    assign alloc_bit = alloc ? (gnts_n'(1) << alloc_id) : '0;

    // released ids are in use, so they never collide with alloc_id
    always_ff @(posedge clk) begin
        if (rst) begin
            free_map <= '1;
        end else begin
            free_map <= (free_map | release_mask) & ~alloc_bit;
        end
    end

    // a release must name a slot that is currently handed out
    assert property (@(posedge clk) disable iff (rst)
        (release_mask & free_map) == '0);

    // no allocation from an empty pool
    assert property (@(posedge clk) disable iff (rst)
        alloc |-> has_free);

endmodule

/* rtl/rr_select.sv */
`timescale 1ns/1ns

module rr_select import arb_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [ports_n-1:0] eligible,
    input  logic               advance,
    output logic [ports_n-1:0] pick,
    output logic               pick_valid
);

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] pick_idx;

    // port index base+offs, wrapped at ports_n
    function automatic logic [ptr_w-1:0] wrap_idx(input logic [ptr_w-1:0] base, input int offs);
        int sum;
        sum = int'(base) + offs;
        if (sum >= ports_n) begin
            sum = sum - ports_n;
        end
        return sum[ptr_w-1:0];
    endfunction

    // first eligible port at or after ptr
    always_comb begin
        pick       = '0;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int k = 0; k < ports_n; k++) begin
            if (!pick_valid && eligible[wrap_idx(ptr, k)]) begin
                pick_valid = 1'b1;
                pick_idx   = wrap_idx(ptr, k);
            end
        end
        if (pick_valid) begin
            pick[pick_idx] = 1'b1;
        end
    end

    // pointer moves one past the granted port, holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (advance && pick_valid) begin
            ptr <= wrap_idx(pick_idx, 1);
        end
    end

    // single pick, and only ever an eligible one
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(pick) && ((pick & ~eligible) == '0));

endmodule

/* rtl/arb_pkg.sv */
package arb_pkg;

    // requesters and channel slots
    localparam int ports_n = 10;
    localparam int gnts_n  = 4;

    // slot id width
    localparam int gnts_w  = 2;

    // round-robin pointer width, enough to index ports_n
    localparam int ptr_w   = 4;

    // grant counter and free-slot count widths
    localparam int cnt_w   = 16;
    localparam int free_w  = 3;

    // apb bus widths
    localparam int apb_aw  = 4;
    localparam int apb_dw  = 32;

    // register map
    // mask is read/write, reset to all ones
    localparam logic [apb_aw-1:0] addr_mask = 4'h0;
    // grant vector, read only
    localparam logic [apb_aw-1:0] addr_gnt  = 4'h4;
    // free-slot count, read only
    localparam logic [apb_aw-1:0] addr_free = 4'h8;
    // grant counter, read only; any write clears it
    localparam logic [apb_aw-1:0] addr_cnt  = 4'hC;

endpackage
